// File: verilog/cl_config.svh
/* Widths, configuration table size, read credit limit,
   identity words and the LED pattern shown after reset */

`ifndef CL_CONFIG_SVH
`define CL_CONFIG_SVH

// ------------------------------
// Datapath widths
// ------------------------------
`define CL_ADDR_W      32
`define CL_DATA_W      32
`define CL_LED_W       16

// ------------------------------
// Configuration table
// ------------------------------
`define CL_CFG_DEPTH   8
// Table plus out-of-range space
`define CL_CFG_AW      4

// Outstanding read limit and count width
`define CL_MAX_RD      4
`define CL_CNT_W       3

// Identity and configuration words
`define CL_ID0_VALUE   32'hC15E_0A01
`define CL_ID1_VALUE   32'h0001_C15E
`define CL_TILES_X     32'd4
`define CL_TILES_Y     32'd4
`define CL_VLED_VALUE  16'hbeef

`endif

// File: verilog/cl_pkg.sv
/* Shared types: address, data, LED, configuration address,
   read count, requester tag and arbiter states */

`include "cl_config.svh"

package cl_pkg;

  // ------------------------------
  // Vector types
  // ------------------------------
  typedef logic [`CL_ADDR_W-1:0]  addr_t;
  typedef logic [`CL_DATA_W-1:0]  data_t;
  typedef logic [`CL_LED_W-1:0]   led_t;
  typedef logic [`CL_CFG_AW-1:0]  cfg_addr_t;
  typedef logic [`CL_CNT_W-1:0]   rd_cnt_t;

  // Requester tag, 0 is host and 1 is core
  typedef logic owner_t;

  // ------------------------------
  // Arbiter states
  // ------------------------------
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_HOST,
    ARB_CORE
  } arb_state_e;

endpackage

// File: verilog/cl_status_regs.sv
/* Virtual LED register, two-flop DIP synchronizer and
   the read-only configuration table */

`include "cl_config.svh"

module cl_status_regs (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  cl_pkg::led_t      vdip_i,
  input  logic              cfg_rd_i,
  input  cl_pkg::cfg_addr_t cfg_addr_i,
  output cl_pkg::led_t      vled_o,
  output logic              cfg_rvalid_o,
  output cl_pkg::data_t     cfg_rdata_o
);

  localparam int IDX_W = $clog2(`CL_CFG_DEPTH);

  cl_pkg::led_t  vdip_q1;
  cl_pkg::led_t  vdip_q2;
  cl_pkg::led_t  vled_q;
  cl_pkg::data_t cfg_table [`CL_CFG_DEPTH];
  cl_pkg::data_t cfg_word;

  // ------------------------------
  // DIP sync and LED pattern
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1 <= '0;
      vdip_q2 <= '0;
      vled_q  <= '0;
    end else begin
      vdip_q1 <= vdip_i;
      vdip_q2 <= vdip_q1;
      vled_q  <= `CL_VLED_VALUE;
    end
  end

  assign vled_o = vled_q;

  // ------------------------------
  // Configuration table
  // ------------------------------
  always_comb begin
    for (int i = 0; i < `CL_CFG_DEPTH; i++) begin
      cfg_table[i] = '0;
    end
    cfg_table[0] = `CL_ID0_VALUE;
    cfg_table[1] = `CL_ID1_VALUE;
    cfg_table[2] = `CL_TILES_X;
    cfg_table[3] = `CL_TILES_Y;
    cfg_table[4] = cl_pkg::data_t'(`CL_MAX_RD);
    // Synchronized switches, zero-extended
    cfg_table[5] = cl_pkg::data_t'(vdip_q2);
  end

  // Anything past the table reads as zero
  assign cfg_word = (cfg_addr_i < cl_pkg::cfg_addr_t'(`CL_CFG_DEPTH)) ?
                    cfg_table[cfg_addr_i[IDX_W-1:0]] : '0;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cfg_rvalid_o <= 1'b0;
    end else begin
      cfg_rvalid_o <= cfg_rd_i;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (cfg_rd_i) begin
      cfg_rdata_o <= cfg_word;
    end
  end

endmodule

// File: verilog/cl_mem_arbiter_fsm.sv
/* Round-robin FSM granting the shared memory request port
   to the host or the core requester */

module cl_mem_arbiter_fsm (
  input  logic           clk_main_a0,
  input  logic           rst_main_n_sync,
  input  logic           host_req_valid_i,
  input  logic           host_req_we_i,
  input  cl_pkg::addr_t  host_req_addr_i,
  input  cl_pkg::data_t  host_req_wdata_i,
  output logic           host_req_ready_o,
  input  logic           core_req_valid_i,
  input  logic           core_req_we_i,
  input  cl_pkg::addr_t  core_req_addr_i,
  input  cl_pkg::data_t  core_req_wdata_i,
  output logic           core_req_ready_o,
  output logic           mem_req_valid_o,
  output logic           mem_req_we_o,
  output cl_pkg::addr_t  mem_req_addr_o,
  output cl_pkg::data_t  mem_req_wdata_o,
  input  logic           mem_req_ready_i,
  input  logic           credit_avail_i,
  output logic           rd_issue_o,
  output cl_pkg::owner_t rd_owner_o
);

  cl_pkg::arb_state_e state_q;
  cl_pkg::arb_state_e state_d;
  cl_pkg::owner_t     last_grant_q;
  logic               host_elig;
  logic               core_elig;
  logic               pick_core;

  // Reads need a free credit, writes are posted
  assign host_elig = host_req_valid_i && (host_req_we_i || credit_avail_i);
  assign core_elig = core_req_valid_i && (core_req_we_i || credit_avail_i);

  // Core wins when alone or when host was granted last
  assign pick_core = core_elig && (!host_elig || (last_grant_q == 1'b0));

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      cl_pkg::ARB_IDLE: begin
        if (pick_core) begin
          state_d = cl_pkg::ARB_CORE;
        end else if (host_elig) begin
          state_d = cl_pkg::ARB_HOST;
        end
      end
      cl_pkg::ARB_HOST, cl_pkg::ARB_CORE: begin
        if (mem_req_ready_i) begin
          state_d = cl_pkg::ARB_IDLE;
        end
      end
      default: state_d = cl_pkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state_q      <= cl_pkg::ARB_IDLE;
      last_grant_q <= 1'b1;
    end else begin
      state_q <= state_d;
      if ((state_q == cl_pkg::ARB_IDLE) && (state_d != cl_pkg::ARB_IDLE)) begin
        last_grant_q <= pick_core;
      end
    end
  end

  // Request copy for the memory port, loaded while idle
  always_ff @(posedge clk_main_a0) begin
    if (state_q == cl_pkg::ARB_IDLE) begin
      mem_req_we_o    <= pick_core ? core_req_we_i    : host_req_we_i;
      mem_req_addr_o  <= pick_core ? core_req_addr_i  : host_req_addr_i;
      mem_req_wdata_o <= pick_core ? core_req_wdata_i : host_req_wdata_i;
    end
  end

  // ------------------------------
  // Handshake outputs
  // ------------------------------
  assign mem_req_valid_o  = (state_q != cl_pkg::ARB_IDLE);
  assign host_req_ready_o = (state_q == cl_pkg::ARB_HOST) && mem_req_ready_i;
  assign core_req_ready_o = (state_q == cl_pkg::ARB_CORE) && mem_req_ready_i;

  // One pulse per accepted read
  assign rd_issue_o = mem_req_valid_o && mem_req_ready_i && !mem_req_we_o;
  assign rd_owner_o = cl_pkg::owner_t'(state_q == cl_pkg::ARB_CORE);

endmodule

// File: verilog/cl_credit_counter.sv
/* Outstanding read counter with a credit-available flag */

`include "cl_config.svh"

module cl_credit_counter (
  input  logic clk_main_a0,
  input  logic rst_main_n_sync,
  input  logic rd_issue_i,
  input  logic mem_rsp_valid_i,
  output logic credit_avail_o
);

  cl_pkg::rd_cnt_t count_q;

  // ------------------------------
  // Count update
  // ------------------------------
  // Issue and return in the same cycle leave the count alone
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      count_q <= '0;
    end else begin
      case ({rd_issue_i, mem_rsp_valid_i})
        2'b10: begin
          count_q <= count_q + cl_pkg::rd_cnt_t'(1);
        end
        2'b01: begin
          count_q <= count_q - cl_pkg::rd_cnt_t'(1);
        end
        default: begin
          count_q <= count_q;
        end
      endcase
    end
  end

  // Room for one more read
  assign credit_avail_o = (count_q < cl_pkg::rd_cnt_t'(`CL_MAX_RD));

endmodule

// File: verilog/cl_resp_router.sv
/* Owner tag queue and read response steering to the
   host or core requester, in issue order */

`include "cl_config.svh"

module cl_resp_router (
  input  logic           clk_main_a0,
  input  logic           rst_main_n_sync,
  input  logic           rd_issue_i,
  input  cl_pkg::owner_t rd_owner_i,
  input  logic           mem_rsp_valid_i,
  input  cl_pkg::data_t  mem_rsp_rdata_i,
  output logic           host_rsp_valid_o,
  output cl_pkg::data_t  host_rsp_rdata_o,
  output logic           core_rsp_valid_o,
  output cl_pkg::data_t  core_rsp_rdata_o
);

  localparam int PTR_W = $clog2(`CL_MAX_RD);

  cl_pkg::owner_t owner_q [`CL_MAX_RD];
  logic [PTR_W:0] wr_ptr_q;
  logic [PTR_W:0] rd_ptr_q;
  logic           queue_empty;
  logic           rsp_take;
  cl_pkg::owner_t head_owner;
  cl_pkg::data_t  rsp_rdata_q;

  // ------------------------------
  // Owner queue
  // ------------------------------
  // Extra pointer bit tells full from empty
  assign queue_empty = (wr_ptr_q == rd_ptr_q);
  assign head_owner  = owner_q[rd_ptr_q[PTR_W-1:0]];
  // Stray response with nothing queued is dropped
  assign rsp_take    = mem_rsp_valid_i && !queue_empty;

  always_ff @(posedge clk_main_a0) begin
    if (rd_issue_i) begin
      owner_q[wr_ptr_q[PTR_W-1:0]] <= rd_owner_i;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_ptr_q         <= '0;
      rd_ptr_q         <= '0;
      host_rsp_valid_o <= 1'b0;
      core_rsp_valid_o <= 1'b0;
    end else begin
      if (rd_issue_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rsp_take) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      host_rsp_valid_o <= rsp_take && (head_owner == 1'b0);
      core_rsp_valid_o <= rsp_take && (head_owner == 1'b1);
    end
  end

  // ------------------------------
  // Response data
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (mem_rsp_valid_i) begin
      rsp_rdata_q <= mem_rsp_rdata_i;
    end
  end

  // Only the flagged requester samples it
  assign host_rsp_rdata_o = rsp_rdata_q;
  assign core_rsp_rdata_o = rsp_rdata_q;

endmodule

// File: verilog/cl_shell_top.sv
/* Shell top: arbiter, credit counter, response router
   and status registers */

module cl_shell_top (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  // Host requester
  input  logic              host_req_valid_i,
  input  logic              host_req_we_i,
  input  cl_pkg::addr_t     host_req_addr_i,
  input  cl_pkg::data_t     host_req_wdata_i,
  output logic              host_req_ready_o,
  output logic              host_rsp_valid_o,
  output cl_pkg::data_t     host_rsp_rdata_o,
  // Core requester
  input  logic              core_req_valid_i,
  input  logic              core_req_we_i,
  input  cl_pkg::addr_t     core_req_addr_i,
  input  cl_pkg::data_t     core_req_wdata_i,
  output logic              core_req_ready_o,
  output logic              core_rsp_valid_o,
  output cl_pkg::data_t     core_rsp_rdata_o,
  // Shared memory port
  output logic              mem_req_valid_o,
  output logic              mem_req_we_o,
  output cl_pkg::addr_t     mem_req_addr_o,
  output cl_pkg::data_t     mem_req_wdata_o,
  input  logic              mem_req_ready_i,
  input  logic              mem_rsp_valid_i,
  input  cl_pkg::data_t     mem_rsp_rdata_i,
  // Status side
  input  logic              cfg_rd_i,
  input  cl_pkg::cfg_addr_t cfg_addr_i,
  output logic              cfg_rvalid_o,
  output cl_pkg::data_t     cfg_rdata_o,
  input  cl_pkg::led_t      vdip_i,
  output cl_pkg::led_t      vled_o
);

  logic           credit_avail;
  logic           rd_issue;
  cl_pkg::owner_t rd_owner;

  // ------------------------------
  // Memory request path
  // ------------------------------
  cl_mem_arbiter_fsm u_arbiter (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .host_req_valid_i (host_req_valid_i),
    .host_req_we_i    (host_req_we_i),
    .host_req_addr_i  (host_req_addr_i),
    .host_req_wdata_i (host_req_wdata_i),
    .host_req_ready_o (host_req_ready_o),
    .core_req_valid_i (core_req_valid_i),
    .core_req_we_i    (core_req_we_i),
    .core_req_addr_i  (core_req_addr_i),
    .core_req_wdata_i (core_req_wdata_i),
    .core_req_ready_o (core_req_ready_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_we_o     (mem_req_we_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_req_wdata_o  (mem_req_wdata_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .credit_avail_i   (credit_avail),
    .rd_issue_o       (rd_issue),
    .rd_owner_o       (rd_owner)
  );

  cl_credit_counter u_credit (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .rd_issue_i      (rd_issue),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .credit_avail_o  (credit_avail)
  );

  // Read data back to its requester
  cl_resp_router u_router (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .rd_issue_i       (rd_issue),
    .rd_owner_i       (rd_owner),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .mem_rsp_rdata_i  (mem_rsp_rdata_i),
    .host_rsp_valid_o (host_rsp_valid_o),
    .host_rsp_rdata_o (host_rsp_rdata_o),
    .core_rsp_valid_o (core_rsp_valid_o),
    .core_rsp_rdata_o (core_rsp_rdata_o)
  );

  cl_status_regs u_status (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .vdip_i          (vdip_i),
    .cfg_rd_i        (cfg_rd_i),
    .cfg_addr_i      (cfg_addr_i),
    .vled_o          (vled_o),
    .cfg_rvalid_o    (cfg_rvalid_o),
    .cfg_rdata_o     (cfg_rdata_o)
  );

endmodule

// File: testbench/cl_shell_checker.sv
/* Concurrent assertions for the arbiter request hold, the read
   credit bound and the response router queue, with bind lines */

`include "cl_config.svh"

module cl_shell_checker (
  input logic            clk_main_a0,
  input logic            rst_main_n_sync,
  input logic            mem_valid_i,
  input logic            mem_ready_i,
  input logic [64:0]     mem_req_i,
  input cl_pkg::rd_cnt_t count_i,
  input logic            rsp_valid_i,
  input logic            queue_empty_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // A stalled request keeps valid and its fields
  a_req_stable: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (mem_valid_i && !mem_ready_i) |=> (mem_valid_i && $stable(mem_req_i)))
    else $error("memory request changed while stalled");

  a_count_bound: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (count_i <= cl_pkg::rd_cnt_t'(`CL_MAX_RD)))
    else $error("outstanding read count above limit");

  a_rsp_queued: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(rsp_valid_i && queue_empty_i))
    else $error("read response with empty owner queue");

endmodule

bind cl_mem_arbiter_fsm cl_shell_checker u_chk_arb (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .mem_valid_i     (mem_req_valid_o),
  .mem_ready_i     (mem_req_ready_i),
  .mem_req_i       ({mem_req_we_o, mem_req_addr_o, mem_req_wdata_o}),
  .count_i         (3'd0),
  .rsp_valid_i     (1'b0),
  .queue_empty_i   (1'b0)
);

bind cl_credit_counter cl_shell_checker u_chk_cnt (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .mem_valid_i     (1'b0),
  .mem_ready_i     (1'b1),
  .mem_req_i       (65'd0),
  .count_i         (count_q),
  .rsp_valid_i     (1'b0),
  .queue_empty_i   (1'b0)
);

bind cl_resp_router cl_shell_checker u_chk_rtr (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .mem_valid_i     (1'b0),
  .mem_ready_i     (1'b1),
  .mem_req_i       (65'd0),
  .count_i         (3'd0),
  .rsp_valid_i     (mem_rsp_valid_i),
  .queue_empty_i   (queue_empty)
);

// File: testbench/tb_cl_shell.sv
/* Shell testbench: clock, reset, memory model, directed tests,
   compare tasks and the closing summary */

`include "cl_config.svh"

module tb_cl_shell;

  timeunit 1ns;
  timeprecision 1ps;

  logic clk_main_a0;
  logic rst_main_n_sync;
  logic host_req_valid_i, host_req_we_i, host_req_ready_o, host_rsp_valid_o;
  logic core_req_valid_i, core_req_we_i, core_req_ready_o, core_rsp_valid_o;
  logic mem_req_valid_o, mem_req_we_o, mem_req_ready_i, mem_rsp_valid_i;
  logic cfg_rd_i, cfg_rvalid_o;
  cl_pkg::addr_t host_req_addr_i, core_req_addr_i, mem_req_addr_o;
  cl_pkg::data_t host_req_wdata_i, core_req_wdata_i, host_rsp_rdata_o, core_rsp_rdata_o;
  cl_pkg::data_t mem_req_wdata_o, mem_rsp_rdata_i, cfg_rdata_o;
  cl_pkg::cfg_addr_t cfg_addr_i;
  cl_pkg::led_t vdip_i, vled_o;

  integer seed = 32'h2c4c;
  int err_cnt = 0;
  int test_cnt = 0;
  int fail_cnt = 0;
  int rd_seen = 0;
  int rsp_lat = 1;
  int rsp_wait = 0;
  int rsp_allow = -1;
  logic stall_on = 1'b0;
  cl_pkg::data_t mem_model [cl_pkg::addr_t];
  cl_pkg::data_t shadow [cl_pkg::addr_t];
  cl_pkg::data_t pend_q [$];
  cl_pkg::data_t host_rsp_q [$];
  cl_pkg::data_t core_rsp_q [$];
  cl_pkg::addr_t acc_addr_q [$];
  cl_pkg::data_t late_exp;

  cl_shell_top u_dut (.*);

  initial begin
    clk_main_a0 = 1'b0;
    forever #20 clk_main_a0 = ~clk_main_a0;
  end

  // Hang guard
  initial begin
    #2000000;
    $display("simulation timed out");
    $display("tests failed");
    $finish;
  end

  // ------------------------------
  // Memory model and monitors
  // ------------------------------
  always @(posedge clk_main_a0) begin
    if (host_rsp_valid_o) host_rsp_q.push_back(host_rsp_rdata_o);
    if (core_rsp_valid_o) core_rsp_q.push_back(core_rsp_rdata_o);
    if (mem_req_valid_o && mem_req_ready_i) begin
      acc_addr_q.push_back(mem_req_addr_o);
      if (mem_req_we_o) begin
        mem_model[mem_req_addr_o] = mem_req_wdata_o;
      end else begin
        pend_q.push_back(mem_model.exists(mem_req_addr_o) ? mem_model[mem_req_addr_o] : '0);
        rd_seen++;
      end
    end
    #2;
    mem_rsp_valid_i = 1'b0;
    if (pend_q.size() > 0 && rsp_allow != 0) begin
      if (rsp_wait >= rsp_lat) begin
        mem_rsp_valid_i = 1'b1;
        mem_rsp_rdata_i = pend_q.pop_front();
        rsp_wait = 0;
        if (rsp_allow > 0) rsp_allow--;
      end else begin
        rsp_wait++;
      end
    end
    mem_req_ready_i = stall_on ? ($random(seed) % 3 != 0) : 1'b1;
  end

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_data(input string name, input cl_pkg::data_t got,
                            input cl_pkg::data_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_led(input string name, input cl_pkg::led_t got,
                           input cl_pkg::led_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input cl_pkg::rd_cnt_t got,
                             input cl_pkg::rd_cnt_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("%s: pass", name);
    end else begin
      fail_cnt++;
      $display("%s: FAIL", name);
    end
  endtask

  // ------------------------------
  // Requester and config helpers
  // ------------------------------
  // Expected read data is taken from the shadow at acceptance
  task automatic send_req(input cl_pkg::owner_t who, input logic we, input cl_pkg::addr_t addr,
                          input cl_pkg::data_t wdata, output cl_pkg::data_t exp,
                          input logic chained = 1'b0);
    logic done;
    int t;
    done = 1'b0;
    exp = '0;
    // A chained request follows the last one with valid kept high
    if (!chained) begin
      @(posedge clk_main_a0);
      #2;
    end
    if (who) begin
      core_req_valid_i = 1'b1;
      core_req_we_i = we;
      core_req_addr_i = addr;
      core_req_wdata_i = wdata;
    end else begin
      host_req_valid_i = 1'b1;
      host_req_we_i = we;
      host_req_addr_i = addr;
      host_req_wdata_i = wdata;
    end
    for (t = 0; t < 200 && !done; t++) begin
      @(posedge clk_main_a0);
      if ((who && core_req_ready_o) || (!who && host_req_ready_o)) begin
        done = 1'b1;
        if (we) shadow[addr] = wdata;
        else exp = shadow.exists(addr) ? shadow[addr] : '0;
      end
    end
    if (!done) begin
      $display("request from %s was never accepted", who ? "core" : "host");
      err_cnt++;
    end
    #2;
    if (who) core_req_valid_i = 1'b0;
    else host_req_valid_i = 1'b0;
  endtask

  task automatic get_rsp(input cl_pkg::owner_t who, input cl_pkg::data_t exp);
    int t;
    t = 0;
    while (((who && core_rsp_q.size() == 0) || (!who && host_rsp_q.size() == 0)) && t < 200) begin
      @(posedge clk_main_a0);
      t++;
    end
    if (who && core_rsp_q.size() > 0) begin
      check_data("core_rsp_rdata_o", core_rsp_q.pop_front(), exp);
    end else if (!who && host_rsp_q.size() > 0) begin
      check_data("host_rsp_rdata_o", host_rsp_q.pop_front(), exp);
    end else begin
      $display("no read response reached the %s requester", who ? "core" : "host");
      err_cnt++;
    end
  endtask

  // Response is due exactly one cycle after the strobe
  task automatic cfg_read(input cl_pkg::cfg_addr_t addr, input cl_pkg::data_t exp);
    @(posedge clk_main_a0);
    #2;
    cfg_rd_i = 1'b1;
    cfg_addr_i = addr;
    @(posedge clk_main_a0);
    #2;
    cfg_rd_i = 1'b0;
    @(posedge clk_main_a0);
    check_data("cfg_rvalid_o", cl_pkg::data_t'(cfg_rvalid_o), 32'd1);
    check_data("cfg_rdata_o", cfg_rdata_o, exp);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_cfg();
    int e;
    e = err_cnt;
    cfg_read(4'd0, `CL_ID0_VALUE);
    cfg_read(4'd1, `CL_ID1_VALUE);
    cfg_read(4'd2, `CL_TILES_X);
    cfg_read(4'd3, `CL_TILES_Y);
    cfg_read(4'd4, 32'd4);
    cfg_read(4'd6, 32'd0);
    cfg_read(4'd7, 32'd0);
    cfg_read(4'd9, 32'd0);
    cfg_read(4'd15, 32'd0);
    // Old switches still read one cycle after a change
    @(posedge clk_main_a0);
    #2;
    vdip_i = 16'hffff;
    cfg_read(4'd5, 32'd0);
    // New switches read two cycles after a change
    #2;
    vdip_i = 16'h5a3c;
    @(posedge clk_main_a0);
    cfg_read(4'd5, 32'h0000_5a3c);
    report("config table", e);
  endtask

  task automatic test_write_read();
    int e;
    cl_pkg::data_t x;
    e = err_cnt;
    stall_on = 1'b1;
    rsp_lat = 2;
    send_req(1'b0, 1'b1, 32'h0000_0080, 32'hcafe_f00d, x);
    send_req(1'b0, 1'b0, 32'h0000_0080, 32'd0, x);
    get_rsp(1'b0, 32'hcafe_f00d);
    stall_on = 1'b0;
    report("host write then read", e);
  endtask

  task automatic test_two_requesters();
    int e;
    cl_pkg::data_t hx, cx;
    e = err_cnt;
    rsp_lat = 1;
    acc_addr_q.delete();
    fork
      begin
        send_req(1'b0, 1'b1, 32'h100, 32'h1111_0001, hx);
        send_req(1'b0, 1'b1, 32'h104, 32'h1111_0002, hx, 1'b1);
        send_req(1'b0, 1'b0, 32'h100, 32'd0, hx, 1'b1);
        send_req(1'b0, 1'b0, 32'h104, 32'd0, hx, 1'b1);
      end
      begin
        send_req(1'b1, 1'b1, 32'h200, 32'h2222_0001, cx);
        send_req(1'b1, 1'b1, 32'h204, 32'h2222_0002, cx, 1'b1);
        send_req(1'b1, 1'b0, 32'h200, 32'd0, cx, 1'b1);
        send_req(1'b1, 1'b0, 32'h204, 32'd0, cx, 1'b1);
      end
    join
    get_rsp(1'b0, 32'h1111_0001);
    get_rsp(1'b0, 32'h1111_0002);
    get_rsp(1'b1, 32'h2222_0001);
    get_rsp(1'b1, 32'h2222_0002);
    for (int i = 1; i < acc_addr_q.size(); i++) begin
      if (acc_addr_q[i][9] == acc_addr_q[i-1][9]) begin
        $display("memory port granted the same requester twice in a row");
        err_cnt++;
      end
    end
    report("two requesters", e);
  endtask

  task automatic test_credit_limit();
    int e;
    int base;
    int t;
    cl_pkg::data_t exp_q [4];
    cl_pkg::data_t x;
    e = err_cnt;
    rsp_lat = 0;
    rsp_allow = 0;
    base = rd_seen;
    for (int i = 0; i < 4; i++) begin
      send_req(1'b0, 1'b0, 32'h100 + 32'(i * 4), 32'd0, exp_q[i]);
    end
    fork
      send_req(1'b0, 1'b0, 32'h300, 32'd0, late_exp);
    join_none
    repeat (10) @(posedge clk_main_a0);
    check_count("reads issued", cl_pkg::rd_cnt_t'(rd_seen - base), 3'd4);
    send_req(1'b1, 1'b1, 32'h304, 32'h3333_0004, x);
    rsp_allow = 1;
    t = 0;
    while (rd_seen - base < 5 && t < 200) begin
      @(posedge clk_main_a0);
      t++;
    end
    check_count("reads issued", cl_pkg::rd_cnt_t'(rd_seen - base), 3'd5);
    repeat (2) @(posedge clk_main_a0);
    rsp_allow = -1;
    for (int i = 0; i < 4; i++) begin
      get_rsp(1'b0, exp_q[i]);
    end
    get_rsp(1'b0, late_exp);
    report("read credit limit", e);
  endtask

  task automatic traffic(input cl_pkg::owner_t who);
    int r;
    int w;
    cl_pkg::data_t exp;
    for (int i = 0; i < 24; i++) begin
      r = $random(seed);
      w = $random(seed);
      send_req(who, r[0], 32'h40 + {27'd0, r[4:2], 2'b00}, cl_pkg::data_t'(w), exp);
      if (!r[0]) get_rsp(who, exp);
    end
  endtask

  task automatic test_random_traffic();
    int e;
    e = err_cnt;
    stall_on = 1'b1;
    rsp_lat = 3;
    fork
      traffic(1'b0);
      traffic(1'b1);
    join
    stall_on = 1'b0;
    report("random mixed traffic", e);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int e;
    rst_main_n_sync = 1'b0;
    {host_req_valid_i, host_req_we_i, core_req_valid_i, core_req_we_i} = '0;
    host_req_addr_i = '0;
    host_req_wdata_i = '0;
    core_req_addr_i = '0;
    core_req_wdata_i = '0;
    mem_req_ready_i = 1'b1;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_rdata_i = '0;
    cfg_rd_i = 1'b0;
    cfg_addr_i = '0;
    vdip_i = '0;
    e = err_cnt;
    repeat (5) @(posedge clk_main_a0);
    check_led("vled_o", vled_o, 16'h0000);
    #2;
    rst_main_n_sync = 1'b1;
    repeat (2) @(posedge clk_main_a0);
    check_led("vled_o", vled_o, `CL_VLED_VALUE);
    check_data("mem_req_valid_o", cl_pkg::data_t'(mem_req_valid_o), 32'd0);
    check_data("host_req_ready_o", cl_pkg::data_t'(host_req_ready_o), 32'd0);
    check_data("core_req_ready_o", cl_pkg::data_t'(core_req_ready_o), 32'd0);
    check_data("host_rsp_valid_o", cl_pkg::data_t'(host_rsp_valid_o), 32'd0);
    check_data("core_rsp_valid_o", cl_pkg::data_t'(core_rsp_valid_o), 32'd0);
    check_data("cfg_rvalid_o", cl_pkg::data_t'(cfg_rvalid_o), 32'd0);
    report("reset values", e);
    test_cfg();
    test_write_read();
    test_two_requesters();
    test_credit_limit();
    test_random_traffic();
    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+verilog
verilog/cl_pkg.sv
verilog/cl_status_regs.sv
verilog/cl_mem_arbiter_fsm.sv
verilog/cl_credit_counter.sv
verilog/cl_resp_router.sv
verilog/cl_shell_top.sv
testbench/cl_shell_checker.sv
testbench/tb_cl_shell.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the shell testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_cl_shell \
  -Mdir obj_dir \
  -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_cl_shell > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1
